//--- source/ppfifo_config_pkg.sv
`default_nettype none

package ppfifo_config_pkg;

  // Word width carried through both banks
  localparam int DATA_WIDTH = 8;

  // Index width within one bank
  localparam int ADDRESS_WIDTH = 4;

  // Words per bank
  localparam int BANK_DEPTH = 1 << ADDRESS_WIDTH;

  // One stored word
  typedef logic [DATA_WIDTH-1:0] data_t;

  // Word index inside a bank
  typedef logic [ADDRESS_WIDTH-1:0] addr_t;

  // Burst length, one bit wider so a full bank fits
  typedef logic [ADDRESS_WIDTH:0] count_t;

  // Bank number, 0 or 1
  typedef logic bank_t;

  // One bit per bank, bit 0 is bank 0
  typedef logic [1:0] bank_mask_t;

endpackage

`default_nettype wire

//--- source/ppfifo_handoff_pkg.sv
`default_nettype none

package ppfifo_handoff_pkg;

  import ppfifo_config_pkg::*;

  // Filled bank handed from write stage to read stage
  typedef struct packed {
    logic   valid;
    bank_t  bank;
    count_t count;
  } bank_commit_t;

  // Bank given back from read stage to write stage
  typedef struct packed {
    logic  valid;
    bank_t bank;
  } bank_release_t;

  // Memory write port request
  typedef struct packed {
    logic  enable;
    bank_t bank;
    addr_t address;
    data_t data;
  } mem_write_t;

  // Memory read port address
  typedef struct packed {
    bank_t bank;
    addr_t address;
  } mem_read_t;

endpackage

`default_nettype wire

//--- source/ppfifo_write_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ppfifo_write_stage
  import ppfifo_config_pkg::*;
  import ppfifo_handoff_pkg::*;
(
  input  wire           write_clock,
  input  wire           reset,
  input  wire bank_mask_t    write_activate,
  input  wire           write_strobe,
  input  wire data_t         write_data,
  input  wire bank_release_t bank_release,
  output bank_mask_t    write_ready,
  output bank_commit_t  commit,
  output mem_write_t    mem_write,
  output logic          inactive
);

  // Words written so far into each bank
  count_t     fill_count [2];
  // Bank handed to the read side and not yet returned
  logic [1:0] committed;
  // Exactly one bank selected, 11 counts as none
  logic       write_valid;
  bank_t      write_bank;
  // Strobe that really lands in memory
  logic       accept;
  // Bank filled and waiting to be committed
  logic [1:0] commit_ready;

  assign write_valid = (write_activate == 2'b01) || (write_activate == 2'b10);
  assign write_bank  = write_activate[1];

  // Saturate at a full bank, never write into a committed bank
  assign accept = write_valid && write_strobe && !committed[write_bank] &&
                  (fill_count[write_bank] < count_t'(BANK_DEPTH));

  // Commit only while the producer holds no bank
  always_comb begin
    for (int b = 0; b < 2; b++) begin
      commit_ready[b] = (write_activate == 2'b00) &&
                        (fill_count[b] != '0) && !committed[b];
    end
  end

  // Memory write goes out in the same cycle as the strobe
  always_comb begin
    mem_write.enable  = accept;
    mem_write.bank    = write_bank;
    mem_write.address = addr_t'(fill_count[write_bank]);
    mem_write.data    = write_data;
  end

  assign inactive = (fill_count[0] == '0) && (fill_count[1] == '0) &&
                    (write_ready == 2'b11) && !write_strobe;

  always_ff @(posedge write_clock) begin
    if (reset) begin
      fill_count[0] <= '0;
      fill_count[1] <= '0;
      committed     <= '0;
      write_ready   <= '0;
      commit        <= '0;
    end else begin
      commit.valid <= 1'b0;

      // Empty free bank is offered again, also covers the first edge out of reset
      for (int b = 0; b < 2; b++) begin
        if ((fill_count[b] == '0) && !committed[b]) begin
          write_ready[b] <= 1'b1;
        end
      end

      // First strobe takes the bank away from the idle pool
      if (accept) begin
        fill_count[write_bank]  <= fill_count[write_bank] + count_t'(1);
        write_ready[write_bank] <= 1'b0;
      end

      // Bank 0 wins a tie, bank 1 follows on the next cycle
      if (commit_ready[0]) begin
        commit.valid <= 1'b1;
        commit.bank  <= 1'b0;
        commit.count <= fill_count[0];
        committed[0] <= 1'b1;
      end else if (commit_ready[1]) begin
        commit.valid <= 1'b1;
        commit.bank  <= 1'b1;
        commit.count <= fill_count[1];
        committed[1] <= 1'b1;
      end

      // Reader is done with the bank
      for (int b = 0; b < 2; b++) begin
        if (bank_release.valid && (bank_release.bank == bank_t'(b))) begin
          fill_count[b]  <= '0;
          committed[b]   <= 1'b0;
          write_ready[b] <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- source/ppfifo_bank_memory.sv
`timescale 1ns/1ps
`default_nettype none

module ppfifo_bank_memory
  import ppfifo_config_pkg::*;
  import ppfifo_handoff_pkg::*;
(
  input  wire             write_clock,
  input  wire mem_write_t mem_write,
  input  wire mem_read_t  mem_read,
  output data_t           read_word
);

  // Bank number is the top address bit
  logic [ADDRESS_WIDTH:0] write_slot;
  logic [ADDRESS_WIDTH:0] read_slot;

  // Both banks in one array
  data_t storage [2*BANK_DEPTH];

  assign write_slot = {mem_write.bank, mem_write.address};
  assign read_slot  = {mem_read.bank, mem_read.address};

  always_ff @(posedge write_clock) begin
    if (mem_write.enable) begin
      storage[write_slot] <= mem_write.data;
    end
  end

  // Registered read, word follows its address by one edge
  always_ff @(posedge write_clock) begin
    read_word <= storage[read_slot];
  end

endmodule

`default_nettype wire

//--- source/ppfifo_read_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ppfifo_read_stage
  import ppfifo_config_pkg::*;
  import ppfifo_handoff_pkg::*;
(
  input  wire               write_clock,
  input  wire               reset,
  input  wire bank_commit_t commit,
  input  wire               read_activate,
  input  wire               read_strobe,
  input  wire data_t        read_word,
  output mem_read_t         mem_read,
  output bank_release_t     bank_release,
  output logic              read_ready,
  output count_t            read_count,
  output data_t             read_data
);

  typedef enum logic [1:0] {
    state_idle,
    state_prime,
    state_active,
    state_drop
  } read_state_t;

  read_state_t state;

  // Committed banks in commit order
  bank_t      queue_bank  [2];
  count_t     queue_count [2];
  logic       queue_head;
  logic [1:0] queue_used;
  logic       queue_tail;

  // Bank held by the reader and the word on show
  bank_t      active_bank;
  addr_t      read_index;

  logic       push;
  logic       take_bank;
  logic       advance;

  assign queue_tail = queue_head ^ queue_used[0];
  assign push       = commit.valid;

  // Offer a bank only while none is held
  assign read_ready = (state == state_idle) && (queue_used != 2'd0);
  assign take_bank  = read_ready && read_activate;

  // Strobes past the last word are dropped
  assign advance = (state == state_active) && read_activate && read_strobe &&
                   ((count_t'(read_index) + count_t'(1)) < read_count);

  // Next address goes out early so strobes can come every cycle
  always_comb begin
    mem_read.bank    = active_bank;
    mem_read.address = advance ? read_index + addr_t'(1) : read_index;
  end

  // Memory output holds while the address stays put
  assign read_data = read_word;

  // Queue payload
  always_ff @(posedge write_clock) begin
    if (push) begin
      queue_bank[queue_tail]  <= commit.bank;
      queue_count[queue_tail] <= commit.count;
    end
  end

  always_ff @(posedge write_clock) begin
    if (reset) begin
      state        <= state_idle;
      queue_head   <= 1'b0;
      queue_used   <= 2'd0;
      active_bank  <= 1'b0;
      read_index   <= '0;
      read_count   <= '0;
      bank_release <= '0;
    end else begin
      bank_release.valid <= 1'b0;

      // Queue occupancy, push and pop may meet
      case ({push, take_bank})
        2'b10:   queue_used <= queue_used + 2'd1;
        2'b01:   queue_used <= queue_used - 2'd1;
        default: queue_used <= queue_used;
      endcase
      if (take_bank) begin
        queue_head <= ~queue_head;
      end

      case (state)
        state_idle: begin
          // Oldest committed bank first
          if (take_bank) begin
            active_bank <= queue_bank[queue_head];
            read_count  <= queue_count[queue_head];
            read_index  <= '0;
            state       <= state_prime;
          end
        end
        state_prime: begin
          // Word 0 is being fetched this cycle
          if (!read_activate) begin
            bank_release.valid <= 1'b1;
            bank_release.bank  <= active_bank;
            state              <= state_drop;
          end else begin
            state <= state_active;
          end
        end
        state_active: begin
          if (!read_activate) begin
            bank_release.valid <= 1'b1;
            bank_release.bank  <= active_bank;
            state              <= state_drop;
          end else if (advance) begin
            read_index <= read_index + addr_t'(1);
          end
        end
        state_drop: begin
          // Release pulse is out, back to offering banks
          read_count <= '0;
          state      <= state_idle;
        end
        default: begin
          state <= state_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/ppfifo.sv
`timescale 1ns/1ps
`default_nettype none

module ppfifo
  import ppfifo_config_pkg::*;
  import ppfifo_handoff_pkg::*;
(
  input  wire             write_clock,
  input  wire             reset,
  input  wire bank_mask_t write_activate,
  input  wire             write_strobe,
  input  wire data_t      write_data,
  input  wire             read_activate,
  input  wire             read_strobe,
  output bank_mask_t      write_ready,
  output logic            read_ready,
  output count_t          read_count,
  output data_t           read_data,
  output logic            inactive
);

  // Stage to stage traffic
  bank_commit_t  commit;
  bank_release_t bank_release;
  mem_write_t    mem_write;
  mem_read_t     mem_read;
  data_t         read_word;

  ppfifo_write_stage i_write_stage (
    .write_clock    (write_clock),
    .reset          (reset),
    .write_activate (write_activate),
    .write_strobe   (write_strobe),
    .write_data     (write_data),
    .bank_release   (bank_release),
    .write_ready    (write_ready),
    .commit         (commit),
    .mem_write      (mem_write),
    .inactive       (inactive)
  );

  ppfifo_bank_memory i_bank_memory (
    .write_clock (write_clock),
    .mem_write   (mem_write),
    .mem_read    (mem_read),
    .read_word   (read_word)
  );

  ppfifo_read_stage i_read_stage (
    .write_clock   (write_clock),
    .reset         (reset),
    .commit        (commit),
    .read_activate (read_activate),
    .read_strobe   (read_strobe),
    .read_word     (read_word),
    .mem_read      (mem_read),
    .bank_release  (bank_release),
    .read_ready    (read_ready),
    .read_count    (read_count),
    .read_data     (read_data)
  );

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic write_clock,
  output logic reset
);

  // 100 ns period
  localparam int half_period = 50;

  initial begin
    write_clock = 1'b0;
    forever #half_period write_clock = ~write_clock;
  end

  // Reset seen by three rising edges, released on the third
  initial begin
    reset = 1'b1;
    repeat (3) @(posedge write_clock);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

//--- sim/tb_ppfifo.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ppfifo
  import ppfifo_config_pkg::*;
();

  // Sum of all test lengths with generous margin
  localparam int watchdog_cycles = 2000;
  // Commit to read_ready takes at most three cycles
  localparam int wait_limit = 10;

  logic       write_clock;
  logic       reset;
  bank_mask_t write_activate;
  logic       write_strobe;
  data_t      write_data;
  logic       read_activate;
  logic       read_strobe;
  bank_mask_t write_ready;
  logic       read_ready;
  count_t     read_count;
  data_t      read_data;
  logic       inactive;

  // Words expected back per bank up to BANK_DEPTH
  data_t       sent_words [2][BANK_DEPTH];
  int          sent_len [2];
  int          error_count;
  int          check_count;
  int          seed;
  int unsigned discard;

  tb_clock_gen i_clock_gen (
    .write_clock (write_clock),
    .reset       (reset)
  );

  ppfifo i_ppfifo (
    .write_clock    (write_clock),
    .reset          (reset),
    .write_activate (write_activate),
    .write_strobe   (write_strobe),
    .write_data     (write_data),
    .read_activate  (read_activate),
    .read_strobe    (read_strobe),
    .write_ready    (write_ready),
    .read_ready     (read_ready),
    .read_count     (read_count),
    .read_data      (read_data),
    .inactive       (inactive)
  );

  task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
    check_count++;
    if (actual !== expected) begin
      $display("MISMATCH time %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("%s: %s", name, (error_count == errors_before) ? "ok" : "fail");
  endtask

  // Polls at the falling edge where outputs are settled
  task automatic wait_for_read_ready(output logic ok);
    int i;
    ok = 1'b0;
    for (i = 0; i < wait_limit && !ok; i++) begin
      @(negedge write_clock);
      if (read_ready) ok = 1'b1;
    end
    if (!ok) begin
      $display("Timeout at %0t: read_ready did not rise within %0d cycles", $time, wait_limit);
      error_count++;
    end
  endtask

  task automatic wait_for_write_ready(input int bank);
    int   i;
    logic ok;
    ok = 1'b0;
    for (i = 0; i < wait_limit && !ok; i++) begin
      @(negedge write_clock);
      if (write_ready[bank]) ok = 1'b1;
    end
    if (!ok) begin
      $display("Timeout at %0t: write_ready of bank %0d stayed low after release", $time, bank);
      error_count++;
    end
  endtask

  // Strobes n random words into a bank, then drops activate
  task automatic write_burst(input int bank, input int n);
    int    i;
    data_t word;
    @(negedge write_clock);
    compare_value(write_ready[bank], 1, "write_ready before burst");
    @(posedge write_clock);
    write_activate <= bank_mask_t'(1 << bank);
    for (i = 0; i < n; i++) begin
      word = data_t'($urandom);
      write_strobe <= 1'b1;
      write_data   <= word;
      // Words past a full bank are dropped by the DUT
      if (i < BANK_DEPTH) sent_words[bank][i] = word;
      @(posedge write_clock);
    end
    write_strobe   <= 1'b0;
    write_activate <= 2'b00;
    sent_len[bank] = (n < BANK_DEPTH) ? n : BANK_DEPTH;
  endtask

  // Takes the offered bank and strobes every cycle
  // Extra strobes land on the last word
  task automatic read_burst(input int bank, input int extra_strobes);
    int   i;
    int   k;
    int   n;
    logic ok;
    n = sent_len[bank];
    wait_for_read_ready(ok);
    if (!ok) return;
    @(posedge write_clock);
    read_activate <= 1'b1;
    // Bank is taken on this edge
    @(posedge write_clock);
    @(negedge write_clock);
    compare_value(read_count, n, "read_count");
    compare_value(read_ready, 0, "read_ready while bank held");
    compare_value(write_ready[bank], 0, "write_ready of bank held by reader");
    // Word 0 shows after this edge
    @(posedge write_clock);
    read_strobe <= 1'b1;
    for (i = 0; i < n + extra_strobes; i++) begin
      k = (i < n) ? i : n - 1;
      @(negedge write_clock);
      compare_value(read_data, sent_words[bank][k], $sformatf("read_data word %0d", i));
      // Held bank is not offered to the producer
      compare_value(write_ready[bank], 0, "write_ready of bank held by reader");
      @(posedge write_clock);
    end
    read_strobe   <= 1'b0;
    read_activate <= 1'b0;
  endtask

  task automatic check_reset_state();
    int errors_before;
    errors_before = error_count;
    @(negedge write_clock);
    compare_value(write_ready, 2'b00, "write_ready in reset");
    compare_value(read_ready, 0, "read_ready in reset");
    compare_value(read_count, 0, "read_count in reset");
    while (reset) @(negedge write_clock);
    // First edge with reset low raises both ready bits
    @(negedge write_clock);
    compare_value(write_ready, 2'b11, "write_ready after reset");
    compare_value(read_ready, 0, "read_ready after reset");
    compare_value(inactive, 1, "inactive after reset");
    report_test("reset state", errors_before);
  endtask

  task automatic single_burst();
    int errors_before;
    int n;
    errors_before = error_count;
    n = 1 + int'($urandom % BANK_DEPTH);
    write_burst(0, n);
    read_burst(0, 0);
    wait_for_write_ready(0);
    report_test("single burst", errors_before);
  endtask

  task automatic ping_pong_order();
    int errors_before;
    errors_before = error_count;
    write_burst(0, 1 + int'($urandom % BANK_DEPTH));
    write_burst(1, 1 + int'($urandom % BANK_DEPTH));
    // Oldest commit comes out first
    read_burst(0, 0);
    read_burst(1, 0);
    wait_for_write_ready(1);
    wait_for_write_ready(0);
    report_test("ping-pong order", errors_before);
  endtask

  task automatic overflow_burst();
    int errors_before;
    errors_before = error_count;
    write_burst(1, BANK_DEPTH + 4);
    read_burst(1, 3);
    wait_for_write_ready(1);
    report_test("overflow", errors_before);
  endtask

  task automatic empty_activation();
    int errors_before;
    int i;
    errors_before = error_count;
    @(posedge write_clock);
    write_activate <= 2'b01;
    repeat (2) @(posedge write_clock);
    write_activate <= 2'b00;
    // Nothing to commit so the bank stays offered
    for (i = 0; i < 6; i++) begin
      @(negedge write_clock);
      compare_value(read_ready, 0, "read_ready after empty activation");
      compare_value(write_ready, 2'b11, "write_ready after empty activation");
    end
    report_test("empty activation", errors_before);
  endtask

  task automatic idle_flag();
    int errors_before;
    errors_before = error_count;
    @(negedge write_clock);
    compare_value(inactive, 1, "inactive before burst");
    write_burst(0, 5);
    @(negedge write_clock);
    compare_value(inactive, 0, "inactive while bank holds data");
    read_burst(0, 0);
    wait_for_write_ready(0);
    compare_value(inactive, 1, "inactive after release");
    report_test("idle flag", errors_before);
  endtask

  initial begin
    seed = 32'he2ea_7b1c;
    discard = $urandom(seed);
    error_count = 0;
    check_count = 0;
    write_activate <= 2'b00;
    write_strobe   <= 1'b0;
    write_data     <= '0;
    read_activate  <= 1'b0;
    read_strobe    <= 1'b0;
    check_reset_state();
    single_burst();
    ping_pong_order();
    overflow_burst();
    empty_activation();
    idle_flag();
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Stops a run that hangs
  initial begin
    repeat (watchdog_cycles) @(posedge write_clock);
    $display("Watchdog expired after %0d cycles, tests did not finish", watchdog_cycles);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- ppfifo.f
source/ppfifo_config_pkg.sv
source/ppfifo_handoff_pkg.sv
source/ppfifo_write_stage.sv
source/ppfifo_bank_memory.sv
source/ppfifo_read_stage.sv
source/ppfifo.sv
sim/tb_clock_gen.sv
sim/tb_ppfifo.sv
